// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int IMM_WIDTH  = 16;

    // jal destination
    localparam logic [REG_ADDR_WIDTH-1:0] LINK_REG = 5'd31;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

endpackage

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr_a,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr_b,
    input  logic                               wr_en,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     wr_data,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     rd_data_a,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     rd_data_b
);
    import cpu_pkg::*;

    logic [DATA_WIDTH-1:0] regs [2**REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle writeback is visible to decode
    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           load_we,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] load_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] load_data,
    input  logic                           hold,
    input  logic                           stall,
    input  logic                           pc_redirect,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] redirect_target,
    output logic                           if_valid,
    output logic [cpu_pkg::DATA_WIDTH-1:0] if_pc,
    output logic [cpu_pkg::DATA_WIDTH-1:0] if_instr
);
    import cpu_pkg::*;

    localparam int IDX_WIDTH = $clog2(IMEM_DEPTH);

    logic [DATA_WIDTH-1:0] imem [IMEM_DEPTH];
    logic [DATA_WIDTH-1:0] pc;

    // program load, word addressed
    always_ff @(posedge clk) begin
        if (hold && load_we) begin
            imem[load_addr[IDX_WIDTH-1:0]] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || hold) begin
            pc <= '0;
        end else if (pc_redirect) begin
            pc <= redirect_target;
        end else if (!stall) begin
            pc <= pc + DATA_WIDTH'(4);
        end
    end

    // wrong-path fetch is squashed on redirect
    always_ff @(posedge clk) begin
        if (rst || hold || pc_redirect) begin
            if_valid <= 1'b0;
        end else if (!stall) begin
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc    <= pc;
            if_instr <= imem[pc[IDX_WIDTH+1:2]];
        end
    end

endmodule

// ==== hw/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               if_valid,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     if_pc,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     if_instr,
    input  logic                               stall,
    input  logic                               wb_valid,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wb_reg,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     wb_data,
    output logic                               pc_redirect,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     redirect_target,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_rs,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_rt,
    output logic                               id_uses_rs,
    output logic                               id_uses_rt,
    output logic                               id_is_branch,
    output logic                               ex_valid,
    output cpu_pkg::alu_op_t                   ex_alu_op,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     ex_operand_a,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     ex_operand_b,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     ex_store_data,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_rs,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_rt,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_dest,
    output logic                               ex_reg_write,
    output logic                               ex_mem_read,
    output logic                               ex_mem_write
);
    import cpu_pkg::*;

    opcode_t                   opcode;
    funct_t                    funct;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [IMM_WIDTH-1:0]      imm;
    logic [DATA_WIDTH-1:0]     ext_imm;
    logic [DATA_WIDTH-1:0]     pc_plus4;
    logic [DATA_WIDTH-1:0]     rs_data;
    logic [DATA_WIDTH-1:0]     rt_data;

    alu_op_t                   alu_op;
    logic [REG_ADDR_WIDTH-1:0] dest;
    logic                      uses_rs, uses_rt, imm_b, zero_ext;
    logic                      reg_write, mem_read, mem_write;
    logic                      is_cond, is_bne, is_jump, is_jr, is_link;
    logic                      taken;

    assign opcode   = opcode_t'(if_instr[OPCODE_MSB -: 6]);
    assign funct    = funct_t'(if_instr[5:0]);
    assign id_rs    = if_instr[RS_LSB +: REG_ADDR_WIDTH];
    assign id_rt    = if_instr[RT_LSB +: REG_ADDR_WIDTH];
    assign rd       = if_instr[RD_LSB +: REG_ADDR_WIDTH];
    assign imm      = if_instr[IMM_WIDTH-1:0];
    assign pc_plus4 = if_pc + DATA_WIDTH'(4);

    // andi and ori take a zero-extended immediate
    assign ext_imm = zero_ext ? {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm}
                              : {{(DATA_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};

    register_file u_regs (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (id_rs),
        .rd_addr_b (id_rt),
        .wr_en     (wb_valid),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data),
        .rd_data_a (rs_data),
        .rd_data_b (rt_data)
    );

    always_comb begin
        alu_op    = ALU_ADD;
        dest      = id_rt;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        imm_b     = 1'b1;
        zero_ext  = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_cond   = 1'b0;
        is_bne    = 1'b0;
        is_jump   = 1'b0;
        is_jr     = 1'b0;
        is_link   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                imm_b     = 1'b0;
                dest      = rd;
                reg_write = 1'b1;
                case (funct)
                    FN_ADD: alu_op = ALU_ADD;
                    FN_SUB: alu_op = ALU_SUB;
                    FN_AND: alu_op = ALU_AND;
                    FN_OR:  alu_op = ALU_OR;
                    FN_SLT: alu_op = ALU_SLT;
                    FN_JR: begin
                        uses_rt   = 1'b0;
                        reg_write = 1'b0;
                        is_jr     = 1'b1;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDI: begin
                uses_rs   = 1'b1;
                reg_write = 1'b1;
            end
            OP_ANDI: begin
                uses_rs   = 1'b1;
                reg_write = 1'b1;
                zero_ext  = 1'b1;
                alu_op    = ALU_AND;
            end
            OP_ORI: begin
                uses_rs   = 1'b1;
                reg_write = 1'b1;
                zero_ext  = 1'b1;
                alu_op    = ALU_OR;
            end
            OP_SLTI: begin
                uses_rs   = 1'b1;
                reg_write = 1'b1;
                alu_op    = ALU_SLT;
            end
            OP_LW: begin
                uses_rs   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                is_cond = 1'b1;
                is_bne  = (opcode == OP_BNE);
            end
            OP_J: is_jump = 1'b1;
            OP_JAL: begin
                is_jump   = 1'b1;
                is_link   = 1'b1;
                reg_write = 1'b1;
                dest      = LINK_REG;
                alu_op    = ALU_PASS_B;
            end
            default: ;
        endcase
    end

    assign id_uses_rs   = if_valid && uses_rs;
    assign id_uses_rt   = if_valid && uses_rt;
    assign id_is_branch = if_valid && (is_cond || is_jr);

    // branches resolve here against the register file values
    assign taken       = is_cond && ((rs_data == rt_data) != is_bne);
    assign pc_redirect = if_valid && !stall && (taken || is_jump || is_jr);

    always_comb begin
        if (is_jr) begin
            redirect_target = rs_data;
        end else if (is_jump) begin
            redirect_target = {pc_plus4[DATA_WIDTH-1:28], if_instr[25:0], 2'b00};
        end else begin
            redirect_target = pc_plus4 + {ext_imm[DATA_WIDTH-3:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || stall || !if_valid) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_valid     <= 1'b1;
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op     <= alu_op;
        ex_operand_a  <= rs_data;
        ex_operand_b  <= is_link ? pc_plus4 : (imm_b ? ext_imm : rt_data);
        ex_store_data <= rt_data;
        ex_rs         <= uses_rs ? id_rs : '0;
        ex_rt         <= uses_rt ? id_rt : '0;
        ex_dest       <= dest;
    end

endmodule

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               ex_valid,
    input  cpu_pkg::alu_op_t                   ex_alu_op,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_operand_a,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_operand_b,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_store_data,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_rs,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_rt,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_dest,
    input  logic                               ex_reg_write,
    input  logic                               ex_mem_read,
    input  logic                               ex_mem_write,
    input  logic                               wb_valid,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wb_reg,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     wb_data,
    output logic                               mem_valid,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     mem_alu_result,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     mem_store_data,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] mem_dest,
    output logic                               mem_reg_write,
    output logic                               mem_mem_read,
    output logic                               mem_mem_write
);
    import cpu_pkg::*;

    fwd_sel_t              fwd_a;
    fwd_sel_t              fwd_b;
    fwd_sel_t              fwd_store;
    logic [DATA_WIDTH-1:0] alu_a;
    logic [DATA_WIDTH-1:0] alu_b;
    logic [DATA_WIDTH-1:0] store_data;
    logic [DATA_WIDTH-1:0] alu_result;

    // MEM wins over WB, r0 is never forwarded
    function automatic fwd_sel_t fwd_pick(input logic [REG_ADDR_WIDTH-1:0] src);
        if (src == '0) begin
            return FWD_REG;
        end
        if (mem_valid && mem_reg_write && !mem_mem_read && mem_dest == src) begin
            return FWD_MEM;
        end
        if (wb_valid && wb_reg == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] fwd_value(input fwd_sel_t sel,
                                                        input logic [DATA_WIDTH-1:0] reg_val);
        case (sel)
            FWD_MEM: return mem_alu_result;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd_a     = fwd_pick(ex_rs);
        // sw carries its offset in operand b
        fwd_b     = ex_mem_write ? FWD_REG : fwd_pick(ex_rt);
        fwd_store = fwd_pick(ex_rt);
    end

    assign alu_a      = fwd_value(fwd_a, ex_operand_a);
    assign alu_b      = fwd_value(fwd_b, ex_operand_b);
    assign store_data = fwd_value(fwd_store, ex_store_data);

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    alu_result = alu_a + alu_b;
            ALU_SUB:    alu_result = alu_a - alu_b;
            ALU_AND:    alu_result = alu_a & alu_b;
            ALU_OR:     alu_result = alu_a | alu_b;
            ALU_SLT:    alu_result = {{(DATA_WIDTH-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_valid && ex_reg_write;
            mem_mem_read  <= ex_valid && ex_mem_read;
            mem_mem_write <= ex_valid && ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= alu_result;
        mem_store_data <= store_data;
        mem_dest       <= ex_dest;
    end

endmodule

// ==== hw/memory_unit.sv ====
`timescale 1ns/1ps

module memory_unit #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               mem_valid,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     mem_alu_result,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     mem_store_data,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] mem_dest,
    input  logic                               mem_reg_write,
    input  logic                               mem_mem_read,
    input  logic                               mem_mem_write,
    output logic                               wb_valid,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wb_reg,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     wb_data
);
    import cpu_pkg::*;

    localparam int IDX_WIDTH = $clog2(DMEM_DEPTH);

    logic [DATA_WIDTH-1:0] dmem [DMEM_DEPTH];
    logic [IDX_WIDTH-1:0]  word_idx;
    logic                  wb_is_load;
    logic [DATA_WIDTH-1:0] wb_alu_result;
    logic [DATA_WIDTH-1:0] wb_load_data;

    // byte address, word aligned
    assign word_idx = mem_alu_result[IDX_WIDTH+1:2];

    always_ff @(posedge clk) begin
        if (mem_valid && mem_mem_write) begin
            dmem[word_idx] <= mem_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid && mem_reg_write && mem_dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg        <= mem_dest;
        wb_is_load    <= mem_mem_read;
        wb_alu_result <= mem_alu_result;
        wb_load_data  <= dmem[word_idx];
    end

    assign wb_data = wb_is_load ? wb_load_data : wb_alu_result;

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic                               load_mode,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_rs,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_rt,
    input  logic                               id_uses_rs,
    input  logic                               id_uses_rt,
    input  logic                               id_is_branch,
    input  logic                               ex_valid,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_dest,
    input  logic                               ex_reg_write,
    input  logic                               ex_mem_read,
    input  logic                               mem_valid,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] mem_dest,
    input  logic                               mem_reg_write,
    output logic                               stall,
    output logic                               hold
);
    import cpu_pkg::*;

    logic ex_match;
    logic mem_match;
    logic load_use;
    logic branch_dep;

    // decode source produced by a stage ahead
    assign ex_match  = ex_valid && ex_reg_write && ex_dest != '0 &&
                       ((id_uses_rs && id_rs == ex_dest) || (id_uses_rt && id_rt == ex_dest));
    assign mem_match = mem_valid && mem_reg_write && mem_dest != '0 &&
                       ((id_uses_rs && id_rs == mem_dest) || (id_uses_rt && id_rt == mem_dest));

    assign load_use   = ex_match && ex_mem_read;
    // branches compare in decode, no forwarding there
    assign branch_dep = id_is_branch && (ex_match || mem_match);

    assign stall = load_use || branch_dep;
    assign hold  = load_mode;

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               load_mode,
    input  logic                               load_we,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     load_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     load_data,
    output logic                               wb_valid,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wb_reg,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     wb_data
);
    import cpu_pkg::*;

    // control from hazard unit and decode
    logic                      stall;
    logic                      hold;
    logic                      pc_redirect;
    logic [DATA_WIDTH-1:0]     redirect_target;

    // IF/ID
    logic                      if_valid;
    logic [DATA_WIDTH-1:0]     if_pc;
    logic [DATA_WIDTH-1:0]     if_instr;

    // decode sources for hazard detection
    logic [REG_ADDR_WIDTH-1:0] id_rs;
    logic [REG_ADDR_WIDTH-1:0] id_rt;
    logic                      id_uses_rs;
    logic                      id_uses_rt;
    logic                      id_is_branch;

    // ID/EX
    logic                      ex_valid;
    alu_op_t                   ex_alu_op;
    logic [DATA_WIDTH-1:0]     ex_operand_a;
    logic [DATA_WIDTH-1:0]     ex_operand_b;
    logic [DATA_WIDTH-1:0]     ex_store_data;
    logic [REG_ADDR_WIDTH-1:0] ex_rs;
    logic [REG_ADDR_WIDTH-1:0] ex_rt;
    logic [REG_ADDR_WIDTH-1:0] ex_dest;
    logic                      ex_reg_write;
    logic                      ex_mem_read;
    logic                      ex_mem_write;

    // EX/MEM
    logic                      mem_valid;
    logic [DATA_WIDTH-1:0]     mem_alu_result;
    logic [DATA_WIDTH-1:0]     mem_store_data;
    logic [REG_ADDR_WIDTH-1:0] mem_dest;
    logic                      mem_reg_write;
    logic                      mem_mem_read;
    logic                      mem_mem_write;

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk             (clk),
        .rst             (rst),
        .load_we         (load_we),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .hold            (hold),
        .stall           (stall),
        .pc_redirect     (pc_redirect),
        .redirect_target (redirect_target),
        .if_valid        (if_valid),
        .if_pc           (if_pc),
        .if_instr        (if_instr)
    );

    decode_unit u_decode (
        .clk             (clk),
        .rst             (rst),
        .if_valid        (if_valid),
        .if_pc           (if_pc),
        .if_instr        (if_instr),
        .stall           (stall),
        .wb_valid        (wb_valid),
        .wb_reg          (wb_reg),
        .wb_data         (wb_data),
        .pc_redirect     (pc_redirect),
        .redirect_target (redirect_target),
        .id_rs           (id_rs),
        .id_rt           (id_rt),
        .id_uses_rs      (id_uses_rs),
        .id_uses_rt      (id_uses_rt),
        .id_is_branch    (id_is_branch),
        .ex_valid        (ex_valid),
        .ex_alu_op       (ex_alu_op),
        .ex_operand_a    (ex_operand_a),
        .ex_operand_b    (ex_operand_b),
        .ex_store_data   (ex_store_data),
        .ex_rs           (ex_rs),
        .ex_rt           (ex_rt),
        .ex_dest         (ex_dest),
        .ex_reg_write    (ex_reg_write),
        .ex_mem_read     (ex_mem_read),
        .ex_mem_write    (ex_mem_write)
    );

    execute_unit u_execute (
        .clk             (clk),
        .rst             (rst),
        .ex_valid        (ex_valid),
        .ex_alu_op       (ex_alu_op),
        .ex_operand_a    (ex_operand_a),
        .ex_operand_b    (ex_operand_b),
        .ex_store_data   (ex_store_data),
        .ex_rs           (ex_rs),
        .ex_rt           (ex_rt),
        .ex_dest         (ex_dest),
        .ex_reg_write    (ex_reg_write),
        .ex_mem_read     (ex_mem_read),
        .ex_mem_write    (ex_mem_write),
        .wb_valid        (wb_valid),
        .wb_reg          (wb_reg),
        .wb_data         (wb_data),
        .mem_valid       (mem_valid),
        .mem_alu_result  (mem_alu_result),
        .mem_store_data  (mem_store_data),
        .mem_dest        (mem_dest),
        .mem_reg_write   (mem_reg_write),
        .mem_mem_read    (mem_mem_read),
        .mem_mem_write   (mem_mem_write)
    );

    memory_unit #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .clk             (clk),
        .rst             (rst),
        .mem_valid       (mem_valid),
        .mem_alu_result  (mem_alu_result),
        .mem_store_data  (mem_store_data),
        .mem_dest        (mem_dest),
        .mem_reg_write   (mem_reg_write),
        .mem_mem_read    (mem_mem_read),
        .mem_mem_write   (mem_mem_write),
        .wb_valid        (wb_valid),
        .wb_reg          (wb_reg),
        .wb_data         (wb_data)
    );

    hazard_unit u_hazard (
        .load_mode       (load_mode),
        .id_rs           (id_rs),
        .id_rt           (id_rt),
        .id_uses_rs      (id_uses_rs),
        .id_uses_rt      (id_uses_rt),
        .id_is_branch    (id_is_branch),
        .ex_valid        (ex_valid),
        .ex_dest         (ex_dest),
        .ex_reg_write    (ex_reg_write),
        .ex_mem_read     (ex_mem_read),
        .mem_valid       (mem_valid),
        .mem_dest        (mem_dest),
        .mem_reg_write   (mem_reg_write),
        .stall           (stall),
        .hold            (hold)
    );

endmodule

// ==== verif/cpu_assertions.sv ====
`timescale 1ns/1ps

module cpu_assertions (
    input logic                               clk,
    input logic                               rst,
    input logic                               stall,
    input logic                               ex_valid,
    input logic                               pc_redirect,
    input logic                               if_valid,
    input cpu_pkg::fwd_sel_t                  fwd_a,
    input cpu_pkg::fwd_sel_t                  fwd_b,
    input cpu_pkg::fwd_sel_t                  fwd_store,
    input logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_rs,
    input logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_rt
);
    import cpu_pkg::*;

    // a stalled decode leaves a bubble in ID/EX
    stall_bubble: assert property (@(posedge clk) disable iff (rst) stall |=> !ex_valid)
        else $error("valid instruction entered ID/EX during a stall");

    redirect_flush: assert property (@(posedge clk) disable iff (rst) pc_redirect |=> !if_valid)
        else $error("IF/ID not flushed after a redirect");

    no_fwd_r0_a: assert property (@(posedge clk) disable iff (rst)
        (fwd_a != FWD_REG) |-> (ex_rs != '0))
        else $error("operand a forwarded for register 0");

    no_fwd_r0_b: assert property (@(posedge clk) disable iff (rst)
        (fwd_b != FWD_REG || fwd_store != FWD_REG) |-> (ex_rt != '0))
        else $error("operand b or store data forwarded for register 0");

endmodule

bind cpu_top cpu_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .ex_valid    (ex_valid),
    .pc_redirect (pc_redirect),
    .if_valid    (if_valid),
    .fwd_a       (u_execute.fwd_a),
    .fwd_b       (u_execute.fwd_b),
    .fwd_store   (u_execute.fwd_store),
    .ex_rs       (ex_rs),
    .ex_rt       (ex_rt)
);

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam int CLK_PERIOD = 20;
    localparam int PAT_DEPTH  = 256;
    localparam int DRAIN      = 20;

    logic        clk;
    logic        rst;
    logic        load_mode;
    logic        load_we;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;

    // word count, program words, then (reg, value) pairs up to an all-ones marker
    logic [31:0] pat [PAT_DEPTH];
    int          n_words;
    int          n_pairs;
    int          exp_idx;
    logic        done;

    cpu_top #(
        .IMEM_DEPTH (256),
        .DMEM_DEPTH (256)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .load_mode (load_mode),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "writeback mismatch");
        end
    endtask

    initial begin
        rst         = 1'b1;
        load_mode   = 1'b1;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        exp_idx     = 0;
        done        = 1'b0;
        n_pairs     = 0;
        $readmemh("verif/cpu_patterns.txt", pat);
        n_words = pat[0];
        while (n_words + 2 + 2 * n_pairs < PAT_DEPTH &&
               pat[n_words + 1 + 2 * n_pairs] !== 32'hffff_ffff) begin
            n_pairs++;
        end
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
        // program load while the core is held at PC 0
        for (int i = 0; i < n_words; i++) begin
            @(posedge clk);
            #2;
            load_we   = 1'b1;
            load_addr = i;
            load_data = pat[i + 1];
        end
        @(posedge clk);
        #2;
        load_we   = 1'b0;
        load_mode = 1'b0;
    end

    // writebacks in program order against the expected pairs
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_idx >= n_pairs) begin
                $display("Unexpected writeback to register %0d with value %h at %0t ns",
                         wb_reg, wb_data, $time);
                $display("Errors found");
                $fatal(1, "extra writeback");
            end else begin
                check_value("wb_reg", 32'(wb_reg), pat[n_words + 1 + 2 * exp_idx]);
                check_value("wb_data", wb_data, pat[n_words + 2 + 2 * exp_idx]);
                exp_idx++;
                if (exp_idx == n_pairs) begin
                    done = 1'b1;
                end
            end
        end
    end

    initial begin
        wait (done);
        // a few more cycles to catch any stray writeback
        repeat (DRAIN) @(negedge clk);
        $display("No errors");
        $finish;
    end

    // watchdog
    initial begin
        #1;
        repeat (n_words * 8 + 100) @(posedge clk);
        $display("Timeout: only %0d of %0d writebacks were seen", exp_idx, n_pairs);
        $display("Errors found");
        $fatal(1, "timeout");
    end

endmodule

// ==== verif/cpu_patterns.txt ====
// word 0: program word count; then the program words
// then pairs of (register index, expected writeback value); ffffffff ends the list
00000020
20010005 2002FFFD 00221820 00222022 00642825 00A43024 0041382A 3048FF00
350900F0 284AFFFC 284B0000 200C1234 AC0C0008 8C0D0008 01A17020 11CE0001
200F0BAD 14210001 200F0077 15E00001 20100BAD 2030FFFB 16000001 08000019
20110BAD 0C00001C 20120022 0800001F 20000007 00019820 03E00008 0800001F
// alu results
00000001 00000005
00000002 FFFFFFFD
00000003 00000002
00000004 00000008
00000005 0000000A
00000006 00000008
00000007 00000001
00000008 0000FF00
00000009 0000FFF0
0000000A 00000000
0000000B 00000001
// store, load and load-use
0000000C 00001234
0000000D 00001234
0000000E 00001239
// branches, then jal link and the call body
0000000F 00000077
00000010 00000000
0000001F 00000068
00000013 00000005
00000012 00000022
FFFFFFFF

// ==== sim.f ====
common/cpu_pkg.sv
hw/register_file.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/memory_unit.sv
hw/hazard_unit.sv
hw/cpu_top.sv
verif/cpu_assertions.sv
verif/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f sim.f -o cpu_sim \
    > build.log 2>&1 \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || echo "Errors found: build or simulation returned a failing status" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log || exit 1
exit 0
